/* include/emg_consts.svh */
`ifndef EMG_CONSTS_SVH
`define EMG_CONSTS_SVH

////////////////////////////////////////
// array sizes
////////////////////////////////////////

// motor units sharing one spike element
`define NUM_UNITS 8
// elements held in the waveform buffer
`define BUF_DEPTH 64
// taps in the action potential template
`define MUAP_LEN 8

////////////////////////////////////////
// action potential template
////////////////////////////////////////

// biphasic shape, tap 0 applies to the newest count
`define MUAP_C0 (0)
`define MUAP_C1 (12)
`define MUAP_C2 (40)
`define MUAP_C3 (64)
`define MUAP_C4 (20)
`define MUAP_C5 (-48)
`define MUAP_C6 (-60)
`define MUAP_C7 (-28)

// signed 18-bit output range
`define EMG_MAX (131071)
`define EMG_MIN (-131072)

`endif

/* rtl/emg_pkg.sv */
`include "emg_consts.svh"

package emg_pkg;

    ////////////////////////////////////////
    // spike data
    ////////////////////////////////////////

    // spikes of one unit in one step
    typedef logic [3:0] spike_count_t;

    // one stored element, unit 0 in the low nibble
    typedef spike_count_t [`NUM_UNITS-1:0] spike_elem_t;

    // one word from the host pipe
    typedef logic [15:0] feed_word_t;

    // write count and read pointer, must reach BUF_DEPTH itself
    typedef logic [$clog2(`BUF_DEPTH + 1)-1:0] buf_count_t;

    // which half of an element the next host word fills
    typedef enum logic
    {
        FEED_LOW,
        FEED_HIGH
    } feed_state_t;

    ////////////////////////////////////////
    // samples
    ////////////////////////////////////////

    // convolution result inside a unit, before the 20-bit output
    typedef logic signed [23:0] mu_acc_t;

    // output of one motor unit
    typedef logic signed [19:0] unit_sample_t;

    // sum of all units before clamping
    typedef logic signed [23:0] emg_sum_t;

    // clamped emg sample
    typedef logic signed [17:0] emg_sample_t;

endpackage

/* rtl/waveform_buffer.sv */
`timescale 1ns/1ps
`include "emg_consts.svh"

module waveform_buffer
    import emg_pkg::*;
(
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic        reset_sim,
    // host words, low half first
    input  logic        feed_valid,
    input  feed_word_t  feed_data,
    // step strobe
    input  logic        tick,
    output logic        buffer_full,
    // replayed element
    output logic        elem_valid,
    output spike_elem_t elem
);

    localparam int ADDR_W = $clog2(`BUF_DEPTH);

    feed_state_t feed_state;
    feed_word_t  low_word;
    buf_count_t  wr_count;
    buf_count_t  rd_ptr;
    logic        wr_en;

    spike_elem_t mem [`BUF_DEPTH];

    ////////////////////////////////////////
    // host side
    ////////////////////////////////////////

    // high word completes a pair
    // pair is dropped once full
    assign wr_en = feed_valid && (feed_state == FEED_HIGH) && !buffer_full;

    // count saturates at depth
    assign buffer_full = (wr_count == buf_count_t'(`BUF_DEPTH));

    // feed fsm and write count
    // reset_sim leaves both alone
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            feed_state <= FEED_LOW;
            wr_count   <= '0;
        end
        else if (feed_valid)
        begin
            case (feed_state)
                FEED_LOW:  feed_state <= FEED_HIGH;
                FEED_HIGH: feed_state <= FEED_LOW;
                default:   feed_state <= FEED_LOW;
            endcase
            if (wr_en)
                wr_count <= wr_count + 1'b1;
        end
    end

    // low half waits here for its partner
    always_ff @(posedge ep50trig)
    begin
        if (feed_valid && (feed_state == FEED_LOW))
            low_word <= feed_data;
    end

    // storage, high word in the upper 16 bits
    always_ff @(posedge ep50trig)
    begin
        if (wr_en)
            mem[wr_count[ADDR_W-1:0]] <= spike_elem_t'({feed_data, low_word});
    end

    ////////////////////////////////////////
    // playback side
    ////////////////////////////////////////

    // pointer and valid, both restart on reset_sim
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || reset_sim)
        begin
            rd_ptr     <= '0;
            elem_valid <= 1'b0;
        end
        else
        begin
            elem_valid <= tick;
            // hold at depth so it never wraps into old data
            if (tick && (rd_ptr != buf_count_t'(`BUF_DEPTH)))
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // element read, silence past the stored data
    always_ff @(posedge ep50trig)
    begin
        if (tick)
        begin
            if (rd_ptr < wr_count)
                elem <= mem[rd_ptr[ADDR_W-1:0]];
            else
                elem <= '0;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // count stays within the memory
    a_wr_count_bound: assert property (@(posedge ep50trig)
        disable iff (reset_global)
        wr_count <= buf_count_t'(`BUF_DEPTH));

    // restart must swallow a pending step
    a_no_valid_after_sim_reset: assert property (@(posedge ep50trig)
        disable iff (reset_global)
        reset_sim |=> !elem_valid);

endmodule

/* rtl/motor_unit_emg.sv */
`timescale 1ns/1ps
`include "emg_consts.svh"

module motor_unit_emg
    import emg_pkg::*;
#(
    // position in the array, also sets the gain
    parameter int UNIT_INDEX = 0
)
(
    input  logic         ep50trig,
    input  logic         reset_global,
    input  logic         reset_sim,
    // this unit's slice of the element
    input  logic         elem_valid,
    input  spike_count_t spike_count,
    output logic         sample_valid,
    output unit_sample_t unit_sample
);

    // unit 0 has gain 1
    localparam mu_acc_t GAIN = mu_acc_t'(UNIT_INDEX + 1);

    // template, tap 0 is the newest count
    localparam logic signed [7:0] MUAP [`MUAP_LEN] = '{
        8'(`MUAP_C0), 8'(`MUAP_C1), 8'(`MUAP_C2), 8'(`MUAP_C3),
        8'(`MUAP_C4), 8'(`MUAP_C5), 8'(`MUAP_C6), 8'(`MUAP_C7)
    };

    // newest count comes straight from the input
    // so the stored part is one tap short
    spike_count_t hist [`MUAP_LEN-1];
    mu_acc_t      conv;
    mu_acc_t      scaled;

    ////////////////////////////////////////
    // convolution
    ////////////////////////////////////////

    // sum over the history as it will be after this shift
    // so the new count already sits in tap 0
    always_comb
    begin
        conv = $signed({1'b0, spike_count}) * MUAP[0];
        for (int k = 1; k < `MUAP_LEN; k++)
        begin
            conv = conv + $signed({1'b0, hist[k-1]}) * MUAP[k];
        end
    end

    // per-unit gain
    assign scaled = conv * GAIN;

    ////////////////////////////////////////
    // history and output
    ////////////////////////////////////////

    // shift register, oldest count falls off the end
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || reset_sim)
        begin
            for (int k = 0; k < `MUAP_LEN - 1; k++)
            begin
                hist[k] <= '0;
            end
            sample_valid <= 1'b0;
        end
        else
        begin
            sample_valid <= elem_valid;
            if (elem_valid)
            begin
                hist[0] <= spike_count;
                for (int k = 1; k < `MUAP_LEN - 1; k++)
                begin
                    hist[k] <= hist[k-1];
                end
            end
        end
    end

    // sample register, only meaningful with sample_valid
    always_ff @(posedge ep50trig)
    begin
        if (elem_valid)
            unit_sample <= unit_sample_t'(scaled);
    end

    // product must fit the 20-bit output
    a_sample_range: assert property (@(posedge ep50trig)
        disable iff (reset_global)
        elem_valid |-> ((scaled <= mu_acc_t'(2**19 - 1)) &&
                        (scaled >= -mu_acc_t'(2**19))));

endmodule

/* rtl/emg_summer.sv */
`timescale 1ns/1ps
`include "emg_consts.svh"

module emg_summer
    import emg_pkg::*;
(
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  logic                  reset_sim,
    // one valid and one sample per unit
    input  logic [`NUM_UNITS-1:0] sample_valid,
    input  unit_sample_t          unit_sample [`NUM_UNITS],
    output logic                  emg_valid,
    output emg_sample_t           emg_out
);

    emg_sum_t sum;
    emg_sum_t clamped;

    ////////////////////////////////////////
    // sum and clamp
    ////////////////////////////////////////

    // full width add, no overflow for eight 20-bit terms
    always_comb
    begin
        sum = '0;
        for (int i = 0; i < `NUM_UNITS; i++)
        begin
            sum = sum + emg_sum_t'(unit_sample[i]);
        end
    end

    // saturate to the 18-bit range
    always_comb
    begin
        if (sum > emg_sum_t'(`EMG_MAX))
            clamped = emg_sum_t'(`EMG_MAX);
        else if (sum < emg_sum_t'(`EMG_MIN))
            clamped = emg_sum_t'(`EMG_MIN);
        else
            clamped = sum;
    end

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////

    // unit 0 stands for all units, they step together
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            emg_valid <= 1'b0;
            emg_out   <= '0;
        end
        else
        begin
            emg_valid <= sample_valid[0] && !reset_sim;
            if (sample_valid[0])
                emg_out <= emg_sample_t'(clamped);
        end
    end

    // all units share one step pipeline
    a_units_in_step: assert property (@(posedge ep50trig)
        disable iff (reset_global)
        sample_valid == {`NUM_UNITS{sample_valid[0]}});

endmodule

/* rtl/emg_sim_top.sv */
`timescale 1ns/1ps
`include "emg_consts.svh"

module emg_sim_top
    import emg_pkg::*;
(
    input  logic               ep50trig,
    input  logic               reset_global,
    input  logic               reset_sim,
    // host pipe
    input  logic               feed_valid,
    input  logic [15:0]        feed_data,
    // step strobe
    input  logic               tick,
    output logic               buffer_full,
    // emg sample, 3 cycles after its tick
    output logic               emg_valid,
    output logic signed [17:0] emg_out
);

    logic                  elem_valid;
    spike_elem_t           elem;
    logic [`NUM_UNITS-1:0] sample_valid;
    unit_sample_t          unit_sample [`NUM_UNITS];

    ////////////////////////////////////////
    // spike storage and playback
    ////////////////////////////////////////

    waveform_buffer u_buffer
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .reset_sim    (reset_sim),
        .feed_valid   (feed_valid),
        .feed_data    (feed_data),
        .tick         (tick),
        .buffer_full  (buffer_full),
        .elem_valid   (elem_valid),
        .elem         (elem)
    );

    ////////////////////////////////////////
    // motor units
    ////////////////////////////////////////

    // unit i reads nibble i, gain i+1
    for (genvar i = 0; i < `NUM_UNITS; i++)
    begin : g_unit
        motor_unit_emg #(.UNIT_INDEX(i)) u_unit
        (
            .ep50trig     (ep50trig),
            .reset_global (reset_global),
            .reset_sim    (reset_sim),
            .elem_valid   (elem_valid),
            .spike_count  (elem[i]),
            .sample_valid (sample_valid[i]),
            .unit_sample  (unit_sample[i])
        );
    end

    // summation and saturation
    emg_summer u_summer
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .reset_sim    (reset_sim),
        .sample_valid (sample_valid),
        .unit_sample  (unit_sample),
        .emg_valid    (emg_valid),
        .emg_out      (emg_out)
    );

endmodule

/* verification/emg_sim_tb.sv */
`timescale 1ns/1ps
`include "emg_consts.svh"

module emg_sim_tb
    import emg_pkg::*;
;
    logic               ep50trig;
    logic               reset_global;
    logic               reset_sim;
    logic               feed_valid;
    logic [15:0]        feed_data;
    logic               tick;
    logic               buffer_full;
    logic               emg_valid;
    logic signed [17:0] emg_out;

    // run limit, well above the few hundred cycles of all tests
    localparam int WATCHDOG_CYCLES = 4000;
    localparam int WAIT_LIMIT = 200;

    emg_sim_top i_dut
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .reset_sim    (reset_sim),
        .feed_valid   (feed_valid),
        .feed_data    (feed_data),
        .tick         (tick),
        .buffer_full  (buffer_full),
        .emg_valid    (emg_valid),
        .emg_out      (emg_out)
    );

    // 100 ns period
    always #50 ep50trig = ~ep50trig;

    ////////////////////////////////////////
    // reference model state
    ////////////////////////////////////////

    int          coef [`MUAP_LEN] = '{`MUAP_C0, `MUAP_C1, `MUAP_C2, `MUAP_C3,
                                      `MUAP_C4, `MUAP_C5, `MUAP_C6, `MUAP_C7};
    logic [31:0] store_m [`BUF_DEPTH];
    int          wr_count_m;
    int          rd_m;
    logic        feed_high_m;
    logic [15:0] low_m;
    int          hist_m [`NUM_UNITS][`MUAP_LEN];
    // expected pipeline, stage 2 is due at the current edge
    logic        pipe_v [3];
    emg_sample_t pipe_d [3];
    emg_sample_t captured [$];
    emg_sample_t first_run [$];
    logic [31:0] rng_state = 32'd98131;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_emg(string name, emg_sample_t got, emg_sample_t exp);
        if (got !== exp)
        begin
            $display("ERROR: time %0t, %s = %0d, expected %0d", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp)
        begin
            $display("ERROR: time %0t, %s = %b, expected %b", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // one step of all units, gain u+1, then clamp
    function automatic emg_sample_t model_step();
        logic [31:0] e;
        int          acc;
        int          total;
        e = (rd_m < wr_count_m) ? store_m[rd_m] : 32'd0;
        rd_m++;
        total = 0;
        for (int u = 0; u < `NUM_UNITS; u++)
        begin
            for (int k = `MUAP_LEN - 1; k > 0; k--)
                hist_m[u][k] = hist_m[u][k-1];
            hist_m[u][0] = int'(e[4*u +: 4]);
            acc = 0;
            for (int k = 0; k < `MUAP_LEN; k++)
                acc += hist_m[u][k] * coef[k];
            total += (u + 1) * acc;
        end
        if (total > `EMG_MAX)
            total = `EMG_MAX;
        else if (total < `EMG_MIN)
            total = `EMG_MIN;
        return emg_sample_t'(total);
    endfunction

    // restart of playback, storage untouched
    function automatic void clear_playback();
        rd_m = 0;
        for (int u = 0; u < `NUM_UNITS; u++)
            for (int k = 0; k < `MUAP_LEN; k++)
                hist_m[u][k] = 0;
        for (int s = 0; s < 3; s++)
            pipe_v[s] = 1'b0;
    endfunction

    ////////////////////////////////////////
    // monitor, sees what the DUT samples
    ////////////////////////////////////////

    always @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            clear_playback();
            wr_count_m  = 0;
            feed_high_m = 1'b0;
        end
        else
        begin
            check_flag("buffer_full", buffer_full, wr_count_m == `BUF_DEPTH);
            check_flag("emg_valid", emg_valid, pipe_v[2]);
            if (pipe_v[2])
                check_emg("emg_out", emg_out, pipe_d[2]);
            if (emg_valid)
                captured.push_back(emg_out);
            pipe_v[2] = pipe_v[1];
            pipe_d[2] = pipe_d[1];
            pipe_v[1] = pipe_v[0];
            pipe_d[1] = pipe_d[0];
            // steps in flight and the current tick are lost
            if (reset_sim)
                clear_playback();
            else
            begin
                pipe_v[0] = tick;
                if (tick)
                    pipe_d[0] = model_step();
            end
            // host pair, low half first
            if (feed_valid && !feed_high_m)
                low_m = feed_data;
            else if (feed_valid && (wr_count_m < `BUF_DEPTH))
            begin
                store_m[wr_count_m] = {feed_data, low_m};
                wr_count_m++;
            end
            if (feed_valid)
                feed_high_m = !feed_high_m;
        end
    end

    ////////////////////////////////////////
    // drivers
    ////////////////////////////////////////

    task automatic go_idle(int n);
        repeat (n)
        begin
            @(posedge ep50trig);
            feed_valid <= 1'b0;
            tick       <= 1'b0;
            reset_sim  <= 1'b0;
        end
    endtask

    task automatic apply_global_reset();
        @(posedge ep50trig);
        reset_global <= 1'b1;
        feed_valid   <= 1'b0;
        tick         <= 1'b0;
        reset_sim    <= 1'b0;
        repeat (4) @(posedge ep50trig);
        reset_global <= 1'b0;
        go_idle(1);
        captured.delete();
    endtask

    // two host words back to back
    task automatic feed_element(logic [31:0] e);
        @(posedge ep50trig);
        feed_valid <= 1'b1;
        feed_data  <= e[15:0];
        @(posedge ep50trig);
        feed_data  <= e[31:16];
    endtask

    // gap 0 gives back-to-back ticks
    task automatic step_tick(int gap);
        @(posedge ep50trig);
        tick <= 1'b1;
        repeat (gap)
        begin
            @(posedge ep50trig);
            tick <= 1'b0;
        end
    endtask

    task automatic random_ticks(int n);
        repeat (n)
            step_tick(int'(next_rand() % 32'd3));
        go_idle(1);
    endtask

    task automatic pulse_sim_reset();
        @(posedge ep50trig);
        reset_sim <= 1'b1;
        tick      <= 1'b0;
        @(posedge ep50trig);
        reset_sim <= 1'b0;
    endtask

    // settle until no step is in flight
    task automatic wait_drain();
        int waited;
        waited = 0;
        do
        begin
            @(negedge ep50trig);
            waited++;
            if (waited > WAIT_LIMIT)
                report_failure("pipeline did not drain in time");
        end
        while (pipe_v[0] || pipe_v[1] || pipe_v[2]);
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * 100);
        report_failure("watchdog expired, the tests did not finish");
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial
    begin
        ep50trig     = 1'b0;
        reset_global = 1'b1;
        reset_sim    = 1'b0;
        feed_valid   = 1'b0;
        feed_data    = '0;
        tick         = 1'b0;
        repeat (4) @(posedge ep50trig);
        reset_global <= 1'b0;
        @(negedge ep50trig);
        check_flag("emg_valid", emg_valid, 1'b0);
        check_flag("buffer_full", buffer_full, 1'b0);
        check_emg("emg_out", emg_out, '0);

        // single spike in unit 3, gain 4
        feed_element(32'h0000_1000);
        go_idle(1);
        random_ticks(`MUAP_LEN);
        wait_drain();
        if (captured.size() != `MUAP_LEN)
            report_failure("impulse test gave the wrong number of samples");
        for (int k = 0; k < `MUAP_LEN; k++)
            check_emg("emg_out impulse tap", captured[k], emg_sample_t'(4 * coef[k]));

        // random data, cut short by reset_sim
        apply_global_reset();
        repeat (40)
            feed_element(next_rand());
        go_idle(1);
        random_ticks(25);
        pulse_sim_reset();
        wait_drain();
        first_run = captured;
        captured.delete();
        // full replay from element 0
        random_ticks(40);
        wait_drain();
        if (captured.size() != 40)
            report_failure("replay gave the wrong number of samples");
        for (int k = 0; k < first_run.size(); k++)
            check_emg("emg_out replay", captured[k], first_run[k]);

        // every count at its maximum
        apply_global_reset();
        repeat (6)
            feed_element(32'hFFFF_FFFF);
        go_idle(1);
        random_ticks(16);
        wait_drain();

        // overfill, then run off the end of the data
        apply_global_reset();
        repeat (`BUF_DEPTH + 6)
            feed_element(next_rand());
        go_idle(1);
        @(negedge ep50trig);
        check_flag("buffer_full", buffer_full, 1'b1);
        random_ticks(`BUF_DEPTH + `MUAP_LEN + 2);
        wait_drain();
        if (captured.size() != `BUF_DEPTH + `MUAP_LEN + 2)
            report_failure("end of data test gave the wrong number of samples");
        // history is all zero once MUAP_LEN empty steps went in
        for (int k = `BUF_DEPTH + `MUAP_LEN - 1; k < captured.size(); k++)
            check_emg("emg_out after end of data", captured[k], '0);

        $display("Testbench passed");
        $finish;
    end

endmodule

/* emg_sim_top.f */
+incdir+include
rtl/emg_pkg.sv
rtl/waveform_buffer.sv
rtl/motor_unit_emg.sv
rtl/emg_summer.sv
rtl/emg_sim_top.sv
verification/emg_sim_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the emg generator testbench
# exit status is nonzero when the simulation stops on $fatal
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
    -f emg_sim_top.f \
    --top-module emg_sim_tb \
    -o emg_sim_tb &&
./obj_dir/emg_sim_tb ||
exit 1
